//--- gyro_radius.mem
// One word per grid row, radius 0 in bits 1:0, radius 1 in bits 3:2, radius 2 in bits 5:4
39
15
2A
3F
29
1E
27
3D
36
1B
25
3A
1F
19
3E
17

//--- project.f
source/grid_solver_pkg.sv
source/delay_pipe.sv
source/gyro_radius_rom.sv
source/stencil_addresser.sv
source/stencil_reducer.sv
source/jacobi_update.sv
source/grid_solver.sv
tests/tb_clock.sv
tests/grid_solver_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module grid_solver_tb -o grid_solver_sim

./obj_dir/grid_solver_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

//--- source/delay_pipe.sv
`timescale 1ns/10ps

module delay_pipe #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic valid,
    input  T     data,
    output logic valid_out,
    output T     data_out
);
    logic [DEPTH-1:0] valid_sr;
    T                 data_sr [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    // Payload only moves with its valid
    always_ff @(posedge clk) begin
        if (valid) begin
            data_sr[0] <= data;
        end
        for (int i = 1; i < DEPTH; i++) begin
            if (valid_sr[i-1]) begin
                data_sr[i] <= data_sr[i-1];
            end
        end
    end

    assign valid_out = valid_sr[DEPTH-1];
    assign data_out  = data_sr[DEPTH-1];

    a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(valid_out));

endmodule

//--- source/grid_solver.sv
`timescale 1ns/10ps

module grid_solver #(
    parameter int NUM_DELTA   = 3,
    parameter int MEM_LATENCY = 1,
    parameter int MULT_STAGES = 3
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   valid,
    input  logic [grid_solver_pkg::GRID_BITS-1:0]                  grid_y,
    input  logic [grid_solver_pkg::GRID_BITS-1:0]                  grid_x,
    input  logic                                                   first_it,
    input  grid_solver_pkg::phi_t [NUM_DELTA-1:0][7:0]             prev_in,
    input  logic [grid_solver_pkg::CHARGE_W-1:0]                   charge_in,
    output logic                                                   valid_out,
    output logic [NUM_DELTA-1:0][7:0][grid_solver_pkg::ADDR_W-1:0] raddr_out,
    output logic [grid_solver_pkg::ADDR_W-1:0]                     charge_addr,
    output logic [grid_solver_pkg::ADDR_W-1:0]                     waddr_out,
    output grid_solver_pkg::phi_t                                  phi_out
);
    import grid_solver_pkg::*;

    typedef struct packed {
        grid_point_t point;
        logic        first_it;
    } point_tag_t;

    grid_point_t                    point_in;
    point_tag_t                     tag_in;
    point_tag_t                     tag_capt;
    logic                           tag_valid;
    logic [NUM_DELTA-1:0][RADIUS_W-1:0] radii;
    point_info_t                    info_capt;
    point_info_t                    info_aligned;
    sum_t [NUM_DELTA-1:0]           sums;
    logic                           sums_valid;

    assign point_in  = '{y: grid_y, x: grid_x};
    assign tag_in    = '{point: point_in, first_it: first_it};
    assign info_capt = '{point: tag_capt.point, first_it: tag_capt.first_it, charge: charge_in};

    gyro_radius_rom #(.NUM_DELTA(NUM_DELTA)) u_rom (
        .clk(clk), .rst(rst), .row(grid_y), .radii(radii)
    );

    stencil_addresser #(.NUM_DELTA(NUM_DELTA)) u_addresser (
        .clk(clk), .rst(rst), .point(point_in), .radii(radii),
        .raddr_out(raddr_out), .charge_addr(charge_addr)
    );

    // Point and flag ride along until the samples return
    delay_pipe #(.T(point_tag_t), .DEPTH(MEM_LATENCY + 2)) u_tag_pipe (
        .clk(clk), .rst(rst), .valid(valid), .data(tag_in),
        .valid_out(tag_valid), .data_out(tag_capt)
    );

    stencil_reducer #(.NUM_DELTA(NUM_DELTA)) u_reducer (
        .clk(clk), .rst(rst), .valid(tag_valid), .first_it(tag_capt.first_it),
        .prev_in(prev_in), .sums(sums), .sums_valid(sums_valid)
    );

    // Charge joins here, three stages to line up with the sums
    delay_pipe #(.T(point_info_t), .DEPTH(3)) u_info_pipe (
        .clk(clk), .rst(rst), .valid(tag_valid), .data(info_capt),
        .valid_out(), .data_out(info_aligned)
    );

    jacobi_update #(.NUM_DELTA(NUM_DELTA), .MULT_STAGES(MULT_STAGES)) u_update (
        .clk(clk), .rst(rst), .sums_valid(sums_valid), .sums(sums), .info(info_aligned),
        .valid_out(valid_out), .waddr_out(waddr_out), .phi_out(phi_out)
    );

endmodule

//--- source/grid_solver_pkg.sv
package grid_solver_pkg;

    //////////////////////////////////////////////////////////////////////
    // Grid and data widths
    //////////////////////////////////////////////////////////////////////

    localparam int GRID_BITS = 4;
    localparam int ADDR_W    = 2 * GRID_BITS;
    localparam int RADIUS_W  = 2;
    localparam int PHI_W     = 16;
    localparam int CHARGE_W  = 12;
    localparam int SUM_W     = 20;   // Twelve full-scale samples
    localparam int ACC_W     = 26;
    localparam int MAX_DELTA = 4;

    //////////////////////////////////////////////////////////////////////
    // Fixed-point constants
    //////////////////////////////////////////////////////////////////////

    // Gyroradius weights, entry 0 is the smallest radius
    localparam int WEIGHT_W = 12;
    localparam logic [MAX_DELTA-1:0][WEIGHT_W-1:0] VWEIGHTS = {
        12'd40, 12'd72, 12'd112, 12'd160
    };
    localparam int WEIGHT_SHIFT = 8;
    localparam int CHARGE_SHIFT = 6;

    // Roughly 1/3 in Q4.12
    localparam logic signed [15:0] DIAG_CONST = 16'sd1365;
    localparam int DIAG_SHIFT = 12;

    typedef logic signed [PHI_W-1:0] phi_t;
    typedef logic signed [SUM_W-1:0] sum_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // Packs to the grid address, row in the upper half
    typedef struct packed {
        logic [GRID_BITS-1:0] y;
        logic [GRID_BITS-1:0] x;
    } grid_point_t;

    typedef struct packed {
        grid_point_t          point;
        logic                 first_it;
        logic [CHARGE_W-1:0]  charge;
    } point_info_t;

endpackage

//--- source/gyro_radius_rom.sv
`timescale 1ns/10ps

module gyro_radius_rom #(
    parameter int NUM_DELTA = 3
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [grid_solver_pkg::GRID_BITS-1:0]               row,
    output logic [NUM_DELTA-1:0][grid_solver_pkg::RADIUS_W-1:0] radii
);
    import grid_solver_pkg::*;

    localparam int ROWS = 1 << GRID_BITS;

    logic [NUM_DELTA-1:0][RADIUS_W-1:0] rom_mem [ROWS];
    logic [GRID_BITS-1:0]               row_q;
    logic                               zero_radius;

    // Radius 0 of a row sits in the low bits of its word
    initial begin
        $readmemh("gyro_radius.mem", rom_mem);
    end

    // Address register, then output register
    always_ff @(posedge clk) begin
        if (rst) begin
            row_q <= '0;
        end else begin
            row_q <= row;
        end
    end

    always_ff @(posedge clk) begin
        radii <= rom_mem[row_q];
    end

    always_comb begin
        zero_radius = 1'b0;
        for (int v = 0; v < NUM_DELTA; v++) begin
            if (radii[v] == '0) begin
                zero_radius = 1'b1;
            end
        end
    end

    // A zero radius would collapse the stencil onto the point itself
    a_radius_nonzero: assert property (@(posedge clk) disable iff (rst) !zero_radius);

endmodule

//--- source/jacobi_update.sv
`timescale 1ns/10ps

module jacobi_update #(
    parameter int NUM_DELTA   = 3,
    parameter int MULT_STAGES = 3
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  sums_valid,
    input  grid_solver_pkg::sum_t [NUM_DELTA-1:0] sums,
    input  grid_solver_pkg::point_info_t          info,
    output logic                                  valid_out,
    output logic [grid_solver_pkg::ADDR_W-1:0]    waddr_out,
    output grid_solver_pkg::phi_t                 phi_out
);
    import grid_solver_pkg::*;

    localparam int WPROD_W = SUM_W + WEIGHT_W + 1;
    localparam int PROD_W  = ACC_W + $bits(DIAG_CONST);

    typedef acc_t [NUM_DELTA-1:0] acc_vec_t;

    typedef struct packed {
        logic [PROD_W-1:0] prod;
        grid_point_t       point;
    } scaled_t;

    acc_vec_t    weighted;
    acc_vec_t    w_vec;
    logic        w_valid;
    point_info_t info_d;
    acc_t        total_sum;
    acc_t        total_q;
    logic        total_valid;
    logic [CHARGE_W-1:0] charge_q;
    grid_point_t point_q;
    acc_t        diff_q;
    grid_point_t diff_point;
    logic        diff_valid;
    scaled_t     scaled_in;
    scaled_t     scaled_d;
    logic        prod_valid;

    //////////////////////////////////////////////////////////////////////
    // Per-gyroradius weighting
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic signed [WPROD_W-1:0] wprod;
        for (int v = 0; v < NUM_DELTA; v++) begin
            wprod       = $signed(sums[v]) * $signed({1'b0, VWEIGHTS[v]});
            weighted[v] = acc_t'(wprod >>> WEIGHT_SHIFT);
        end
    end

    delay_pipe #(.T(acc_vec_t), .DEPTH(MULT_STAGES)) u_weight_pipe (
        .clk(clk), .rst(rst), .valid(sums_valid), .data(weighted),
        .valid_out(w_valid), .data_out(w_vec)
    );

    delay_pipe #(.T(point_info_t), .DEPTH(MULT_STAGES)) u_info_pipe (
        .clk(clk), .rst(rst), .valid(sums_valid), .data(info),
        .valid_out(), .data_out(info_d)
    );

    always_comb begin
        total_sum = '0;
        for (int v = 0; v < NUM_DELTA; v++) begin
            total_sum = total_sum + $signed(w_vec[v]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            total_valid <= 1'b0;
            diff_valid  <= 1'b0;
            valid_out   <= 1'b0;
            waddr_out   <= '0;
            phi_out     <= '0;
        end else begin
            total_valid <= w_valid;
            diff_valid  <= total_valid;
            valid_out   <= prod_valid;
            // Keep the low PHI_W bits of the scaled result
            if (prod_valid) begin
                phi_out   <= phi_t'($signed(scaled_d.prod) >>> DIAG_SHIFT);
                waddr_out <= scaled_d.point;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_valid) begin
            total_q  <= total_sum;
            charge_q <= info_d.charge;
            point_q  <= info_d.point;
        end
        if (total_valid) begin
            diff_q     <= acc_t'({charge_q, {CHARGE_SHIFT{1'b0}}}) - total_q;
            diff_point <= point_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Diagonal scale
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        scaled_in.prod  = diff_q * DIAG_CONST;
        scaled_in.point = diff_point;
    end

    delay_pipe #(.T(scaled_t), .DEPTH(MULT_STAGES)) u_diag_pipe (
        .clk(clk), .rst(rst), .valid(diff_valid), .data(scaled_in),
        .valid_out(prod_valid), .data_out(scaled_d)
    );

    a_update_latency: assert property (@(posedge clk) disable iff (rst)
        sums_valid |-> ##(2*MULT_STAGES+3) valid_out);

endmodule

//--- source/stencil_addresser.sv
`timescale 1ns/10ps

module stencil_addresser #(
    parameter int NUM_DELTA = 3
) (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  grid_solver_pkg::grid_point_t                             point,
    input  logic [NUM_DELTA-1:0][grid_solver_pkg::RADIUS_W-1:0]      radii,
    output logic [NUM_DELTA-1:0][7:0][grid_solver_pkg::ADDR_W-1:0]   raddr_out,
    output logic [grid_solver_pkg::ADDR_W-1:0]                       charge_addr
);
    import grid_solver_pkg::*;

    // Point follows the two ROM cycles
    grid_point_t                       point_q;
    grid_point_t                       point_qq;
    grid_point_t [NUM_DELTA-1:0][7:0]  stencil;

    always_ff @(posedge clk) begin
        point_q  <= point;
        point_qq <= point_q;
    end

    //////////////////////////////////////////////////////////////////////
    // Stencil coordinates, modulo 16 through the 4-bit arithmetic
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [GRID_BITS-1:0] r1;
        logic [GRID_BITS-1:0] r2;
        for (int v = 0; v < NUM_DELTA; v++) begin
            r1 = GRID_BITS'(radii[v]);
            r2 = r1 << 1;
            // Diagonals
            stencil[v][0] = '{y: point_qq.y - r1, x: point_qq.x - r1};
            stencil[v][1] = '{y: point_qq.y - r1, x: point_qq.x + r1};
            stencil[v][2] = '{y: point_qq.y + r1, x: point_qq.x - r1};
            stencil[v][3] = '{y: point_qq.y + r1, x: point_qq.x + r1};
            // Axials at twice the radius
            stencil[v][4] = '{y: point_qq.y - r2, x: point_qq.x};
            stencil[v][5] = '{y: point_qq.y + r2, x: point_qq.x};
            stencil[v][6] = '{y: point_qq.y, x: point_qq.x - r2};
            stencil[v][7] = '{y: point_qq.y, x: point_qq.x + r2};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            raddr_out   <= '0;
            charge_addr <= '0;
        end else begin
            raddr_out   <= stencil;
            charge_addr <= point_qq;
        end
    end

endmodule

//--- source/stencil_reducer.sv
`timescale 1ns/10ps

module stencil_reducer #(
    parameter int NUM_DELTA = 3
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     valid,
    input  logic                                     first_it,
    input  grid_solver_pkg::phi_t [NUM_DELTA-1:0][7:0] prev_in,
    output grid_solver_pkg::sum_t [NUM_DELTA-1:0]      sums,
    output logic                                     sums_valid
);
    import grid_solver_pkg::*;

    phi_t [NUM_DELTA-1:0][7:0] samples;
    sum_t [NUM_DELTA-1:0][1:0] diag_part;
    sum_t [NUM_DELTA-1:0][1:0] axial_part;
    logic                      capt_valid;
    logic                      part_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            capt_valid <= 1'b0;
            part_valid <= 1'b0;
            sums_valid <= 1'b0;
        end else begin
            capt_valid <= valid;
            part_valid <= capt_valid;
            sums_valid <= part_valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Capture, pair sums, final stencil sum
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // First sweep starts from a zero potential
        if (valid) begin
            samples <= first_it ? '0 : prev_in;
        end
        if (capt_valid) begin
            for (int v = 0; v < NUM_DELTA; v++) begin
                diag_part[v][0]  <= $signed(samples[v][0]) + $signed(samples[v][1]);
                diag_part[v][1]  <= $signed(samples[v][2]) + $signed(samples[v][3]);
                axial_part[v][0] <= $signed(samples[v][4]) + $signed(samples[v][5]);
                axial_part[v][1] <= $signed(samples[v][6]) + $signed(samples[v][7]);
            end
        end
        if (part_valid) begin
            for (int v = 0; v < NUM_DELTA; v++) begin
                // Diagonals count double
                sums[v] <= (($signed(diag_part[v][0]) + $signed(diag_part[v][1])) <<< 1)
                           + $signed(axial_part[v][0]) + $signed(axial_part[v][1]);
            end
        end
    end

    // Memory must have answered every stencil read of a presented sum
    a_sums_known: assert property (@(posedge clk) disable iff (rst)
        sums_valid |-> !$isunknown(sums));

endmodule

//--- tests/grid_solver_tb.sv
`timescale 1ns/10ps

module grid_solver_tb;
    import grid_solver_pkg::*;

    localparam int NUM_DELTA   = 3;
    localparam int MEM_LATENCY = 1;
    localparam int MULT_STAGES = 3;
    // Edges from the valid sample to the result register
    localparam int LATENCY     = 7 + MEM_LATENCY + 2 * MULT_STAGES;
    // Edges from the valid sample to the address register
    localparam int ADDR_LATENCY = 2;
    localparam int TIMEOUT     = 200;
    localparam int DLY_TAP     = (MEM_LATENCY > 1) ? MEM_LATENCY - 2 : 0;

    typedef logic [NUM_DELTA-1:0][7:0][ADDR_W-1:0] raddr_vec_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        phi_t              phi;
        logic [31:0]       due;
    } expect_t;

    typedef struct packed {
        raddr_vec_t        raddr;
        logic [ADDR_W-1:0] caddr;
        logic [31:0]       due;
    } addr_expect_t;

    logic                               clk;
    logic                               rst;
    logic                               valid;
    logic [GRID_BITS-1:0]               grid_y;
    logic [GRID_BITS-1:0]               grid_x;
    logic                               first_it;
    phi_t [NUM_DELTA-1:0][7:0]          prev_in;
    logic [CHARGE_W-1:0]                charge_in;
    logic                               valid_out;
    raddr_vec_t                         raddr_out;
    logic [ADDR_W-1:0]                  charge_addr;
    logic [ADDR_W-1:0]                  waddr_out;
    phi_t                               phi_out;

    phi_t                               phi_mem [256];
    logic [CHARGE_W-1:0]                charge_mem [256];
    logic [NUM_DELTA-1:0][RADIUS_W-1:0] radius_tab [16];
    raddr_vec_t                         raddr_dly [MEM_LATENCY];
    logic [ADDR_W-1:0]                  caddr_dly [MEM_LATENCY];
    raddr_vec_t                         raddr_mem;
    logic [ADDR_W-1:0]                  caddr_mem;

    expect_t                            expected_q [$];
    addr_expect_t                       addr_q [$];
    logic [31:0]                        rng_state = 32'hdfcae52b;
    int                                 cycle = 0;
    int                                 errors = 0;
    int                                 checks = 0;

    tb_clock u_clock (.clk(clk), .rst(rst));

    grid_solver #(
        .NUM_DELTA(NUM_DELTA), .MEM_LATENCY(MEM_LATENCY), .MULT_STAGES(MULT_STAGES)
    ) UUT (
        .clk(clk), .rst(rst), .valid(valid), .grid_y(grid_y), .grid_x(grid_x),
        .first_it(first_it), .prev_in(prev_in), .charge_in(charge_in),
        .valid_out(valid_out), .raddr_out(raddr_out), .charge_addr(charge_addr),
        .waddr_out(waddr_out), .phi_out(phi_out)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Memory model, data answers addresses MEM_LATENCY edges old
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        raddr_dly[0] <= raddr_out;
        caddr_dly[0] <= charge_addr;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            raddr_dly[i] <= raddr_dly[i-1];
            caddr_dly[i] <= caddr_dly[i-1];
        end
    end

    assign raddr_mem = (MEM_LATENCY == 1) ? raddr_out : raddr_dly[DLY_TAP];
    assign caddr_mem = (MEM_LATENCY == 1) ? charge_addr : caddr_dly[DLY_TAP];

    always_comb begin
        for (int v = 0; v < NUM_DELTA; v++) begin
            for (int k = 0; k < 8; k++) begin
                prev_in[v][k] = $isunknown(raddr_mem[v][k]) ? '0 : phi_mem[raddr_mem[v][k]];
            end
        end
        charge_in = $isunknown(caddr_mem) ? '0 : charge_mem[caddr_mem];
    end

    //////////////////////////////////////////////////////////////////////
    // Random source and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Low four bits give the wrapped coordinate
    function automatic longint phi_at(input int y, input int x);
        return longint'(phi_mem[{GRID_BITS'(y), GRID_BITS'(x)}]);
    endfunction

    function automatic phi_t expected_phi(input int y, input int x, input logic first);
        longint total;
        longint diag;
        longint axial;
        longint diff;
        longint prod;
        int     r;
        total = 0;
        for (int v = 0; v < NUM_DELTA; v++) begin
            r     = int'(radius_tab[y][v]);
            diag  = 0;
            axial = 0;
            if (!first) begin
                diag  = phi_at(y - r, x - r) + phi_at(y - r, x + r)
                      + phi_at(y + r, x - r) + phi_at(y + r, x + r);
                axial = phi_at(y - 2 * r, x) + phi_at(y + 2 * r, x)
                      + phi_at(y, x - 2 * r) + phi_at(y, x + 2 * r);
            end
            total += ((2 * diag + axial) * longint'(VWEIGHTS[v])) >>> WEIGHT_SHIFT;
        end
        diff = (longint'(charge_mem[{GRID_BITS'(y), GRID_BITS'(x)}]) <<< CHARGE_SHIFT) - total;
        prod = diff * longint'(DIAG_CONST);
        return phi_t'(prod >>> DIAG_SHIFT);
    endfunction

    // Diagonals first, then the axials at twice the radius
    function automatic raddr_vec_t expected_raddr(input int y, input int x);
        raddr_vec_t a;
        int         r;
        for (int v = 0; v < NUM_DELTA; v++) begin
            r       = int'(radius_tab[y][v]);
            a[v][0] = {GRID_BITS'(y - r), GRID_BITS'(x - r)};
            a[v][1] = {GRID_BITS'(y - r), GRID_BITS'(x + r)};
            a[v][2] = {GRID_BITS'(y + r), GRID_BITS'(x - r)};
            a[v][3] = {GRID_BITS'(y + r), GRID_BITS'(x + r)};
            a[v][4] = {GRID_BITS'(y - 2 * r), GRID_BITS'(x)};
            a[v][5] = {GRID_BITS'(y + 2 * r), GRID_BITS'(x)};
            a[v][6] = {GRID_BITS'(y), GRID_BITS'(x - 2 * r)};
            a[v][7] = {GRID_BITS'(y), GRID_BITS'(x + 2 * r)};
        end
        return a;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks, driver and result monitor
    //////////////////////////////////////////////////////////////////////

    task automatic check_phi(input phi_t got, input phi_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %02h, expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_point(input int y, input int x, input logic first);
        expect_t      e;
        addr_expect_t a;
        e.addr = {GRID_BITS'(y), GRID_BITS'(x)};
        e.phi  = expected_phi(y, x, first);
        // Sampled at the next edge, seen by the monitor one edge after the result loads
        e.due  = cycle + LATENCY + 1;
        expected_q.push_back(e);
        a.raddr = expected_raddr(y, x);
        a.caddr = e.addr;
        a.due   = cycle + ADDR_LATENCY + 1;
        addr_q.push_back(a);
        valid    = 1'b1;
        grid_y   = GRID_BITS'(y);
        grid_x   = GRID_BITS'(x);
        first_it = first;
        idle_cycles(1);
        valid = 1'b0;
    endtask

    task automatic wait_results(input string name);
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < TIMEOUT) begin
            idle_cycles(1);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("Timeout in %s: %0d results never arrived", name, expected_q.size());
            errors++;
            expected_q.delete();
            addr_q.delete();
        end
        idle_cycles(3);
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("Test %s done with no errors", name);
        end else begin
            $display("Test %s done with %0d errors", name, errors - err0);
        end
    endtask

    always @(posedge clk) begin
        expect_t e;
        if (!rst && valid_out) begin
            if (expected_q.size() == 0) begin
                $display("Unexpected result at %0t for address %02h", $time, waddr_out);
                errors++;
            end else begin
                e = expected_q.pop_front();
                check_addr(waddr_out, e.addr, "waddr_out");
                check_phi(phi_out, e.phi, "phi_out");
                if (cycle != e.due) begin
                    $display("Result for %02h came in cycle %0d instead of cycle %0d",
                             e.addr, cycle, e.due);
                    errors++;
                end
            end
        end
    end

    // Stencil and charge addresses of each point, in the cycle they are issued
    always @(posedge clk) begin
        addr_expect_t a;
        if (!rst && addr_q.size() != 0) begin
            a = addr_q[0];
            if (cycle == a.due) begin
                addr_q.delete(0);
                check_addr(charge_addr, a.caddr, "charge_addr");
                for (int v = 0; v < NUM_DELTA; v++) begin
                    for (int k = 0; k < 8; k++) begin
                        check_addr(raddr_out[v][k], a.raddr[v][k],
                                   $sformatf("raddr_out[%0d][%0d]", v, k));
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_idle_after_reset();
        int err0;
        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            if (valid_out !== 1'b0) begin
                $display("valid_out went high at %0t with no point sent", $time);
                errors++;
            end
            check_phi(phi_out, '0, "idle phi_out");
            check_addr(waddr_out, '0, "idle waddr_out");
            idle_cycles(1);
        end
        report_test("idle_after_reset", err0);
    endtask

    task automatic test_first_iteration();
        int err0;
        err0 = errors;
        send_point(5, 9, 1'b1);
        wait_results("first_iteration");
        report_test("first_iteration", err0);
    endtask

    task automatic test_wrap_corners();
        int err0;
        int ys [6] = '{0, 15, 0, 15, 0, 8};
        int xs [6] = '{0, 15, 15, 0, 7, 15};
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            send_point(ys[i], xs[i], 1'b0);
            wait_results("wrap_corners");
        end
        report_test("wrap_corners", err0);
    endtask

    task automatic test_full_sweep();
        int          err0;
        logic [31:0] rnd;
        err0 = errors;
        for (int a = 0; a < 256; a++) begin
            rnd = next_random();
            send_point(a / 16, a % 16, rnd[0]);
        end
        wait_results("full_sweep");
        report_test("full_sweep", err0);
    endtask

    task automatic test_random_gaps();
        int          err0;
        logic [31:0] rnd;
        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            rnd = next_random();
            send_point(int'(rnd[7:4]), int'(rnd[3:0]), rnd[8]);
            idle_cycles(int'(rnd[23:16]) % 6);
        end
        wait_results("random_gaps");
        report_test("random_gaps", err0);
    endtask

    initial begin
        int waited;
        valid    = 1'b0;
        grid_y   = '0;
        grid_x   = '0;
        first_it = 1'b0;
        $readmemh("gyro_radius.mem", radius_tab);
        for (int a = 0; a < 256; a++) begin
            phi_mem[a]    = phi_t'(next_random());
            charge_mem[a] = CHARGE_W'(next_random());
        end

        @(posedge clk);
        waited = 0;
        while (rst !== 1'b0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            $display("Reset was never released");
            errors++;
        end
        idle_cycles(1);

        test_idle_after_reset();
        test_first_iteration();
        test_wrap_corners();
        test_full_sweep();
        test_random_gaps();

        $display("Tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release just after a rising edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule
